/* design/dsp_macros.svh */
`ifndef DSP_MACROS_SVH
`define DSP_MACROS_SVH

// Sample and accumulator widths
`define DSP_DATA_WIDTH 16
`define DSP_FULL_WIDTH (2 * `DSP_DATA_WIDTH + 8)

// Channel register bank
`define DSP_N_CHANNELS 16
`define DSP_CHAN_BITS 4

// Execution branches
`define DSP_N_BRANCHES 2
`define DSP_BRANCH_ALU 0
`define DSP_BRANCH_MAC 1

`define DSP_COMMIT_ID_WIDTH 4
`define DSP_PROG_DEPTH 32
`define DSP_PC_BITS 5

`endif

/* design/dsp_pkg.sv */
`include "dsp_macros.svh"

package dsp_pkg;

	// Codes 5 to 7 execute as pass_a
	typedef enum logic [2:0] {
		alu_add    = 3'd0,
		alu_sub    = 3'd1,
		alu_pass_a = 3'd2,
		alu_asr1_a = 3'd3,
		alu_neg_a  = 3'd4
	} alu_op_t;

	// One instruction word, two decodings selected by the top bit
	typedef union packed {
		struct packed {
			logic                        branch;
			alu_op_t                     op;
			logic [`DSP_CHAN_BITS-1:0]   dest;
			logic [`DSP_CHAN_BITS-1:0]   src_a;
			logic [`DSP_CHAN_BITS-1:0]   src_b;
		} alu;
		struct packed {
			logic                        branch;
			logic                        overwrite;
			logic [5:0]                  unused;
			logic [`DSP_CHAN_BITS-1:0]   src_a;
			logic [`DSP_CHAN_BITS-1:0]   src_b;
		} mac;
	} instr_t;

endpackage

/* design/issue_if.sv */
`include "dsp_macros.svh"

interface issue_if;

	logic                            valid;
	logic                            ready;
	logic [`DSP_DATA_WIDTH-1:0]      operand_a;
	logic [`DSP_DATA_WIDTH-1:0]      operand_b;
	dsp_pkg::instr_t                 instr;
	logic [`DSP_COMMIT_ID_WIDTH-1:0] commit_id;

	modport issuer (
		output valid, operand_a, operand_b, instr, commit_id,
		input  ready
	);
	modport branch (
		input  valid, operand_a, operand_b, instr, commit_id,
		output ready
	);

endinterface

/* design/branch_if.sv */
`include "dsp_macros.svh"

interface branch_if;

	logic                            valid;
	logic                            ready;
	logic [`DSP_FULL_WIDTH-1:0]      result;
	logic [`DSP_CHAN_BITS-1:0]       dest;
	logic [`DSP_COMMIT_ID_WIDTH-1:0] commit_id;
	logic                            overwrite;

	modport producer (
		output valid, result, dest, commit_id, overwrite,
		input  ready
	);
	modport committer (
		input  valid, result, dest, commit_id, overwrite,
		output ready
	);

endinterface

/* design/dsp_config_regs.sv */
`include "dsp_macros.svh"

module dsp_config_regs (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         wb_cyc,
	input  logic                         wb_stb,
	input  logic                         wb_we,
	input  logic [7:0]                   wb_adr,
	input  logic [`DSP_DATA_WIDTH-1:0]   wb_dat_w,
	output logic [`DSP_DATA_WIDTH-1:0]   wb_dat_r,
	output logic                         wb_ack,
	input  logic                         busy,
	output logic                         enable,
	output logic [`DSP_PC_BITS:0]        prog_len,
	input  logic [`DSP_PC_BITS-1:0]      pc,
	output dsp_pkg::instr_t              instr,
	output logic [`DSP_CHAN_BITS-1:0]    rd_chan,
	input  logic [`DSP_DATA_WIDTH-1:0]   rd_chan_data,
	input  logic [`DSP_FULL_WIDTH-1:0]   acc_value
);

	logic [`DSP_DATA_WIDTH-1:0] prog_mem [`DSP_PROG_DEPTH];
	logic [`DSP_DATA_WIDTH-1:0] rd_value;
	logic                       wb_req;

	// First cycle of a classic cycle only
	assign wb_req = wb_cyc && wb_stb && !wb_ack;

	assign rd_chan = wb_adr[`DSP_CHAN_BITS-1:0];
	assign instr = prog_mem[pc];

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_ack   <= 1'b0;
			enable   <= 1'b0;
			prog_len <= 1;
		end else begin
			wb_ack <= wb_req;
			if (wb_req && wb_we) begin
				case (wb_adr)
					8'h00: enable <= wb_dat_w[0];
					8'h01: prog_len <= wb_dat_w[`DSP_PC_BITS:0];
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wb_req && wb_we && wb_adr[7:5] == 3'b010)
			prog_mem[wb_adr[`DSP_PC_BITS-1:0]] <= wb_dat_w;
		if (wb_req)
			wb_dat_r <= rd_value;
	end

	always_comb begin
		rd_value = '0;
		if (wb_adr[7:4] == 4'h1)
			rd_value = rd_chan_data;
		else case (wb_adr)
			8'h00: rd_value = {15'd0, enable};
			8'h01: rd_value = {10'd0, prog_len};
			8'h02: rd_value = {15'd0, busy};
			8'h20: rd_value = acc_value[15:0];
			8'h21: rd_value = acc_value[31:16];
			// Guard bits, sign-extended
			8'h22: rd_value = {{8{acc_value[39]}}, acc_value[39:32]};
			default: ;
		endcase
	end

endmodule

/* design/instr_issue.sv */
`include "dsp_macros.svh"

module instr_issue (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         enable,
	input  logic                         sample_tick,
	input  logic [`DSP_PC_BITS:0]        prog_len,
	output logic [`DSP_PC_BITS-1:0]      pc,
	input  dsp_pkg::instr_t              instr,
	output logic                         busy,
	output logic [`DSP_CHAN_BITS-1:0]    rd_a,
	output logic [`DSP_CHAN_BITS-1:0]    rd_b,
	input  logic [`DSP_DATA_WIDTH-1:0]   rd_a_data,
	input  logic [`DSP_DATA_WIDTH-1:0]   rd_b_data,
	input  logic                         chan_we,
	input  logic [`DSP_CHAN_BITS-1:0]    chan_addr,
	issue_if.issuer                      alu_port,
	issue_if.issuer                      mac_port
);

	logic [`DSP_N_CHANNELS-1:0]      pending, set_mask, clr_mask;
	logic [`DSP_COMMIT_ID_WIDTH-1:0] next_id;
	logic [`DSP_PC_BITS:0]           pc_count;
	logic [1:0]                      mac_inflight;
	logic run_active, is_mac, hazard, load;
	logic slot_valid, slot_mac, slot_take;

	assign is_mac = instr.mac.branch;
	assign rd_a = instr.alu.src_a;
	assign rd_b = instr.alu.src_b;
	assign hazard = pending[rd_a] | pending[rd_b] | (!is_mac && pending[instr.alu.dest]);
	assign slot_take = slot_mac ? mac_port.ready : alu_port.ready;
	assign load = run_active && enable && !hazard && (!slot_valid || slot_take);
	assign pc_count = {1'b0, pc} + 1'b1;

	// Tick holds channel 0 until the sample write lands
	assign set_mask = ((load && !is_mac) ? (16'd1 << instr.alu.dest) : 16'd0)
		| (sample_tick ? 16'd1 : 16'd0);
	assign clr_mask = chan_we ? (16'd1 << chan_addr) : 16'd0;

	assign alu_port.valid = slot_valid && !slot_mac;
	assign mac_port.valid = slot_valid && slot_mac;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			run_active <= 1'b0;
			pc <= '0;
			pending <= '0;
			slot_valid <= 1'b0;
			next_id <= '0;
			mac_inflight <= '0;
		end else begin
			pending <= (pending & ~clr_mask) | set_mask;
			// Shadow of the two MAC stages, which move only on ready
			if (mac_port.ready)
				mac_inflight <= {mac_inflight[0], mac_port.valid};
			if (load)
				slot_valid <= 1'b1;
			else if (slot_take)
				slot_valid <= 1'b0;
			if (load)
				next_id <= next_id + 1'b1;
			if (sample_tick && enable && !busy) begin
				busy <= 1'b1;
				run_active <= 1'b1;
				pc <= '0;
			end else if (load) begin
				pc <= pc + 1'b1;
				if (pc_count >= prog_len)
					run_active <= 1'b0;
			end else if (!run_active && !slot_valid && pending == '0 && mac_inflight == '0) begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			slot_mac <= is_mac;
			alu_port.instr <= instr;
			alu_port.operand_a <= rd_a_data;
			alu_port.operand_b <= rd_b_data;
			alu_port.commit_id <= next_id;
		end
	end

	assign mac_port.instr = alu_port.instr;
	assign mac_port.operand_a = alu_port.operand_a;
	assign mac_port.operand_b = alu_port.operand_b;
	assign mac_port.commit_id = alu_port.commit_id;

endmodule

/* design/alu_branch.sv */
`include "dsp_macros.svh"

module alu_branch (
	input  logic       clk,
	input  logic       reset,
	issue_if.branch    issue,
	branch_if.producer out
);

	logic [`DSP_DATA_WIDTH-1:0] a, b, alu_value;
	logic                       accept;

	assign a = issue.operand_a;
	assign b = issue.operand_b;

	// Slot empty or emptying this cycle
	assign accept = !out.valid || out.ready;
	assign issue.ready = accept;
	assign out.overwrite = 1'b0;

	always_comb begin
		case (issue.instr.alu.op)
			dsp_pkg::alu_add:    alu_value = a + b;
			dsp_pkg::alu_sub:    alu_value = a - b;
			dsp_pkg::alu_pass_a: alu_value = a;
			dsp_pkg::alu_asr1_a: alu_value = $signed(a) >>> 1;
			dsp_pkg::alu_neg_a:  alu_value = -a;
			default:             alu_value = a;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			out.valid <= 1'b0;
		else if (accept)
			out.valid <= issue.valid;
	end

	always_ff @(posedge clk) begin
		if (accept && issue.valid) begin
			out.result <= {{(`DSP_FULL_WIDTH - `DSP_DATA_WIDTH){alu_value[`DSP_DATA_WIDTH-1]}},
				alu_value};
			out.dest <= issue.instr.alu.dest;
			out.commit_id <= issue.commit_id;
		end
	end

endmodule

/* design/mac_branch.sv */
`include "dsp_macros.svh"

module mac_branch (
	input  logic       clk,
	input  logic       reset,
	issue_if.branch    issue,
	branch_if.producer out
);

	logic signed [`DSP_DATA_WIDTH-1:0]   s1_a, s1_b;
	logic signed [2*`DSP_DATA_WIDTH-1:0] product;
	logic [`DSP_COMMIT_ID_WIDTH-1:0]     s1_id;
	logic                                s1_valid, s1_overwrite;
	logic                                advance;

	// Whole pipe moves together or not at all
	assign advance = !out.valid || out.ready;
	assign issue.ready = advance;
	assign out.dest = '0;

	assign product = s1_a * s1_b;

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			out.valid <= 1'b0;
		end else if (advance) begin
			s1_valid <= issue.valid;
			out.valid <= s1_valid;
		end
	end

	// ************************************************************
	// Operand stage, then product stage
	// ************************************************************
	always_ff @(posedge clk) begin
		if (advance) begin
			s1_a <= issue.operand_a;
			s1_b <= issue.operand_b;
			s1_overwrite <= issue.instr.mac.overwrite;
			s1_id <= issue.commit_id;
			out.result <= {{(`DSP_FULL_WIDTH - 2 * `DSP_DATA_WIDTH){product[2*`DSP_DATA_WIDTH-1]}},
				product};
			out.overwrite <= s1_overwrite;
			out.commit_id <= s1_id;
		end
	end

endmodule

/* design/commit_master.sv */
`include "dsp_macros.svh"

module commit_master (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         enable,
	input  logic                         sample_tick,
	input  logic [`DSP_DATA_WIDTH-1:0]   sample_in,
	branch_if.committer                  alu_res,
	branch_if.committer                  mac_res,
	output logic                         chan_we,
	output logic [`DSP_CHAN_BITS-1:0]    chan_addr,
	output logic [`DSP_DATA_WIDTH-1:0]   chan_wdata,
	output logic                         acc_we,
	output logic                         acc_add,
	output logic [`DSP_FULL_WIDTH-1:0]   acc_wdata
);

	logic [`DSP_COMMIT_ID_WIDTH-1:0] next_commit_id;
	logic [`DSP_N_BRANCHES-1:0]      take;
	logic                            open;

	// Nothing commits on a tick cycle or while disabled
	assign open = enable && !sample_tick;

	assign take[`DSP_BRANCH_ALU] = open && alu_res.valid && alu_res.commit_id == next_commit_id;
	assign take[`DSP_BRANCH_MAC] = open && mac_res.valid && mac_res.commit_id == next_commit_id;

	assign alu_res.ready = take[`DSP_BRANCH_ALU];
	assign mac_res.ready = take[`DSP_BRANCH_MAC];

	always_ff @(posedge clk) begin
		if (reset) begin
			next_commit_id <= '0;
			chan_we <= 1'b0;
			acc_we <= 1'b0;
			acc_add <= 1'b0;
		end else begin
			chan_we <= sample_tick || take[`DSP_BRANCH_ALU];
			acc_we <= take[`DSP_BRANCH_MAC];
			acc_add <= take[`DSP_BRANCH_MAC] && !mac_res.overwrite;
			if (|take)
				next_commit_id <= next_commit_id + 1'b1;
		end
	end

	// ************************************************************
	// Write data, one cycle behind the handshake
	// ************************************************************
	always_ff @(posedge clk) begin
		if (sample_tick) begin
			chan_addr <= '0;
			chan_wdata <= sample_in;
		end else if (take[`DSP_BRANCH_ALU]) begin
			chan_addr <= alu_res.dest;
			chan_wdata <= alu_res.result[`DSP_DATA_WIDTH-1:0];
		end
		if (take[`DSP_BRANCH_MAC])
			acc_wdata <= mac_res.result;
	end

endmodule

/* design/channel_regs.sv */
`include "dsp_macros.svh"

module channel_regs (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         chan_we,
	input  logic [`DSP_CHAN_BITS-1:0]    chan_addr,
	input  logic [`DSP_DATA_WIDTH-1:0]   chan_wdata,
	input  logic                         acc_we,
	input  logic                         acc_add,
	input  logic [`DSP_FULL_WIDTH-1:0]   acc_wdata,
	input  logic [`DSP_CHAN_BITS-1:0]    rd_a,
	input  logic [`DSP_CHAN_BITS-1:0]    rd_b,
	input  logic [`DSP_CHAN_BITS-1:0]    rd_c,
	output logic [`DSP_DATA_WIDTH-1:0]   rd_a_data,
	output logic [`DSP_DATA_WIDTH-1:0]   rd_b_data,
	output logic [`DSP_DATA_WIDTH-1:0]   rd_c_data,
	output logic [`DSP_FULL_WIDTH-1:0]   acc_value
);

	logic [`DSP_DATA_WIDTH-1:0] chan [`DSP_N_CHANNELS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `DSP_N_CHANNELS; i++)
				chan[i] <= '0;
			acc_value <= '0;
		end else begin
			if (chan_we)
				chan[chan_addr] <= chan_wdata;
			// Add wraps at the full width
			if (acc_we)
				acc_value <= acc_add ? acc_value + acc_wdata : acc_wdata;
		end
	end

	assign rd_a_data = chan[rd_a];
	assign rd_b_data = chan[rd_b];
	assign rd_c_data = chan[rd_c];

endmodule

/* design/dsp_core.sv */
`include "dsp_macros.svh"

module dsp_core (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         wb_cyc,
	input  logic                         wb_stb,
	input  logic                         wb_we,
	input  logic [7:0]                   wb_adr,
	input  logic [`DSP_DATA_WIDTH-1:0]   wb_dat_w,
	output logic [`DSP_DATA_WIDTH-1:0]   wb_dat_r,
	output logic                         wb_ack,
	input  logic                         sample_tick,
	input  logic [`DSP_DATA_WIDTH-1:0]   sample_in
);

	logic                         enable, busy;
	logic [`DSP_PC_BITS:0]        prog_len;
	logic [`DSP_PC_BITS-1:0]      pc;
	dsp_pkg::instr_t              instr;
	logic [`DSP_CHAN_BITS-1:0]    rd_a, rd_b, rd_c;
	logic [`DSP_DATA_WIDTH-1:0]   rd_a_data, rd_b_data, rd_c_data;
	logic                         chan_we, acc_we, acc_add;
	logic [`DSP_CHAN_BITS-1:0]    chan_addr;
	logic [`DSP_DATA_WIDTH-1:0]   chan_wdata;
	logic [`DSP_FULL_WIDTH-1:0]   acc_wdata, acc_value;

	issue_if  alu_issue ();
	issue_if  mac_issue ();
	branch_if alu_result ();
	branch_if mac_result ();

	dsp_config_regs u_config (.clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
		.wb_dat_r, .wb_ack, .busy, .enable, .prog_len, .pc, .instr,
		.rd_chan(rd_c), .rd_chan_data(rd_c_data), .acc_value);

	instr_issue u_issue (.clk, .reset, .enable, .sample_tick, .prog_len, .pc, .instr, .busy,
		.rd_a, .rd_b, .rd_a_data, .rd_b_data, .chan_we, .chan_addr,
		.alu_port(alu_issue.issuer), .mac_port(mac_issue.issuer));

	alu_branch u_alu (.clk, .reset, .issue(alu_issue.branch), .out(alu_result.producer));

	mac_branch u_mac (.clk, .reset, .issue(mac_issue.branch), .out(mac_result.producer));

	commit_master u_commit (.clk, .reset, .enable, .sample_tick, .sample_in,
		.alu_res(alu_result.committer), .mac_res(mac_result.committer),
		.chan_we, .chan_addr, .chan_wdata, .acc_we, .acc_add, .acc_wdata);

	channel_regs u_regs (.clk, .reset, .chan_we, .chan_addr, .chan_wdata, .acc_we, .acc_add,
		.acc_wdata, .rd_a, .rd_b, .rd_c, .rd_a_data, .rd_b_data, .rd_c_data, .acc_value);

endmodule

/* testbench/dsp_core_tb.sv */
module dsp_core_tb;

	timeunit 1ns;
	timeprecision 1ps;

	logic        clk, reset;
	logic        wb_cyc, wb_stb, wb_we;
	logic [7:0]  wb_adr;
	logic [15:0] wb_dat_w, wb_dat_r;
	logic        wb_ack;
	logic        sample_tick;
	logic [15:0] sample_in;

	integer      seed;
	int          errors, tests_run, tests_failed;
	logic [15:0] m_chan [16];
	logic [39:0] m_acc;
	logic [15:0] prog [32];
	event        timeout_hit;

	dsp_core dut (.clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
		.wb_dat_r, .wb_ack, .sample_tick, .sample_in);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Ends the run after any timed-out wait
	initial begin
		@(timeout_hit);
		$display("tests failed");
		$finish;
	end

	task automatic report_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		-> timeout_hit;
	endtask

	task automatic check16(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			$display("Error: %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	// ************************************************************
	// Wishbone classic cycles
	// ************************************************************
	task automatic bus_cycle(input logic we, input logic [7:0] adr, input logic [15:0] data,
		output logic [15:0] rdata);
		int n;
		n = 0;
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_adr <= adr;
		wb_dat_w <= data;
		@(negedge clk);
		while (!wb_ack && n < 50) begin
			n++;
			@(negedge clk);
		end
		if (!wb_ack)
			report_timeout("wb_ack");
		rdata = wb_dat_r;
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
	endtask

	task automatic wb_write(input logic [7:0] adr, input logic [15:0] data);
		logic [15:0] unused;
		bus_cycle(1'b1, adr, data, unused);
	endtask

	task automatic wb_read(input logic [7:0] adr, output logic [15:0] data);
		bus_cycle(1'b0, adr, 16'h0, data);
	endtask

	task automatic send_tick(input logic [15:0] value);
		@(posedge clk);
		sample_tick <= 1'b1;
		sample_in <= value;
		@(posedge clk);
		sample_tick <= 1'b0;
	endtask

	task automatic wait_idle();
		logic [15:0] status;
		int n;
		n = 0;
		wb_read(8'h02, status);
		while (status[0] && n < 200) begin
			n++;
			wb_read(8'h02, status);
		end
		if (status[0])
			report_timeout("busy to fall");
	endtask

	// ************************************************************
	// Sequential model
	// ************************************************************
	function automatic logic [15:0] alu_model(input logic [2:0] op, input logic [15:0] a,
		input logic [15:0] b);
		case (op)
			3'd0: return a + b;
			3'd1: return a - b;
			3'd3: return {a[15], a[15:1]};
			3'd4: return 16'd0 - a;
			default: return a;
		endcase
	endfunction

	task automatic run_model(input int len);
		logic [15:0] w;
		logic signed [31:0] p;
		logic [39:0] ext;
		for (int i = 0; i < len; i++) begin
			w = prog[i];
			if (w[15]) begin
				p = $signed(m_chan[w[7:4]]) * $signed(m_chan[w[3:0]]);
				ext = {{8{p[31]}}, p};
				m_acc = w[14] ? ext : m_acc + ext;
			end else begin
				m_chan[w[11:8]] = alu_model(w[14:12], m_chan[w[7:4]], m_chan[w[3:0]]);
			end
		end
	endtask

	// Kind 0 ALU only, 1 MAC only, 2 mixed on channels 0 to 3
	function automatic logic [15:0] gen_instr(input int kind);
		logic [15:0] r;
		r = 16'($random(seed));
		if (kind == 0)
			r[15] = 1'b0;
		else if (kind == 1)
			r[15] = 1'b1;
		else begin
			r[11:10] = 2'b00;
			r[7:6] = 2'b00;
			r[3:2] = 2'b00;
		end
		return r;
	endfunction

	task automatic load_program(input int len, input int kind);
		for (int i = 0; i < len; i++) begin
			prog[i] = gen_instr(kind);
			wb_write(8'h40 + i[7:0], prog[i]);
		end
		wb_write(8'h01, len[15:0]);
	endtask

	task automatic check_channels();
		logic [15:0] v;
		for (int i = 0; i < 16; i++) begin
			wb_read(8'h10 + i[7:0], v);
			check16($sformatf("channel %0d", i), v, m_chan[i]);
		end
	endtask

	task automatic check_acc();
		logic [15:0] v;
		wb_read(8'h20, v);
		check16("acc[15:0]", v, m_acc[15:0]);
		wb_read(8'h21, v);
		check16("acc[31:16]", v, m_acc[31:16]);
		wb_read(8'h22, v);
		check16("acc[39:32]", v, {{8{m_acc[39]}}, m_acc[39:32]});
	endtask

	task automatic run_program(input int len);
		logic [15:0] s;
		s = 16'($random(seed));
		m_chan[0] = s;
		send_tick(s);
		wait_idle();
		run_model(len);
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d mismatches", tests_run, name, errors - errs_before);
		end
	endtask

	initial begin
		int e, len;
		logic [15:0] v, w;
		seed = 32'hdc11;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		reset = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = 8'h0;
		wb_dat_w = 16'h0;
		sample_tick = 1'b0;
		sample_in = 16'h0;
		for (int i = 0; i < 16; i++)
			m_chan[i] = 16'h0;
		m_acc = 40'h0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;

		e = errors;
		for (int i = 0; i < 4; i++) begin
			w = 16'($random(seed));
			wb_write(8'h00, w);
			wb_read(8'h00, v);
			check16("control", v, {15'd0, w[0]});
			len = 1 + ($unsigned($random(seed)) % 32);
			wb_write(8'h01, len[15:0]);
			wb_read(8'h01, v);
			check16("prog_len", v, len[15:0]);
		end
		wb_write(8'h00, 16'h0);
		wb_read(8'h02, v);
		check16("status", v, 16'h0);
		finish_test("register read-back", e);

		e = errors;
		w = 16'($random(seed));
		m_chan[0] = w;
		send_tick(w);
		wb_read(8'h02, v);
		check16("status", v, 16'h0);
		check_channels();
		finish_test("tick while disabled", e);

		e = errors;
		wb_write(8'h00, 16'h1);
		for (int r = 0; r < 5; r++) begin
			len = 1 + ($unsigned($random(seed)) % 32);
			load_program(len, 0);
			run_program(len);
			check_channels();
		end
		finish_test("ALU programs", e);

		e = errors;
		for (int r = 0; r < 6; r++) begin
			len = 1 + ($unsigned($random(seed)) % 32);
			load_program(len, 1);
			run_program(len);
			check_acc();
		end
		// Full-scale products carry the accumulator past bit 39 and round 2^40
		for (int i = 0; i < 32; i++) begin
			prog[i] = 16'h8000;
			wb_write(8'h40 + i[7:0], prog[i]);
		end
		wb_write(8'h01, 16'd32);
		for (int r = 0; r < 36; r++) begin
			m_chan[0] = 16'h8000;
			send_tick(16'h8000);
			wait_idle();
			run_model(32);
			check_acc();
		end
		finish_test("MAC programs", e);

		e = errors;
		for (int r = 0; r < 3; r++) begin
			len = 1 + ($unsigned($random(seed)) % 32);
			load_program(len, 2);
			for (int k = 0; k < 8; k++) begin
				run_program(len);
				check_channels();
				check_acc();
			end
		end
		finish_test("mixed dependent programs", e);

		$display("summary: %0d run, %0d passed, %0d failed, %0d mismatches",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (tests_failed == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* dsp_core.f */
+incdir+design
design/dsp_pkg.sv
design/issue_if.sv
design/branch_if.sv
design/dsp_config_regs.sv
design/instr_issue.sv
design/alu_branch.sv
design/mac_branch.sv
design/commit_master.sv
design/channel_regs.sv
design/dsp_core.sv
testbench/dsp_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= dsp_core.f
TB_TOP    ?= dsp_core_tb
RTL_TOP   ?= dsp_core
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_TEXT ?= all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(OBJ_DIR)/V$(TB_TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TB_TOP)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(OBJ_DIR)
